//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := tb_tube_display
FILELIST  := tube_display_top.f
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

# exit status of the simulation is the test result
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- bench/tb_tube_display.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tube_display
    import tube_pkg::*;
    import vend_pkg::*;
();

    localparam int    SCAN_PERIOD    = 4;
    localparam int    RESET_CYCLES   = 3;
    localparam int    SETTLE_CYCLES  = 2;
    localparam int    MAX_VECTORS    = 32;
    localparam int    RANDOM_VECTORS = 6;
    localparam int    ROUND_CYCLES   = DIGIT_COUNT * SCAN_PERIOD;
    localparam logic [31:0] LCG_SEED = 32'h353b;
    localparam string STIM_FILE      = "bench/tube_display_stim.txt";

    // vector layout: mode nibble, number, glyphs of digit 7 down to digit 0
    localparam int FRAME_LSB  = 0;
    localparam int NUMBER_LSB = $bits(frame_t);
    localparam int MODE_LSB   = NUMBER_LSB + NUMBER_WIDTH;
    localparam int VEC_WIDTH  = MODE_LSB + 4;

    // common anode patterns for 0..9
    localparam glyph_t DIGIT_GLYPHS [10] = '{
        8'hC0, 8'hF9, 8'hA4, 8'hB0, 8'h99, 8'h92, 8'h82, 8'hF8, 8'h80, 8'h90
    };

    logic                    clk;
    logic                    arst_n;
    mode_t                   mode;
    logic [NUMBER_WIDTH-1:0] number;
    glyph_t                  tube_char;
    logic [DIGIT_COUNT-1:0]  tube_switch;

    logic [VEC_WIDTH-1:0]    stim_mem [MAX_VECTORS];
    int                      vector_count;
    int                      total_vectors;
    logic [31:0]             lcg_state;
    logic [NUMBER_WIDTH-1:0] rand_number;

    initial clk = 1'b0;
    always #10 clk = ~clk;

    tube_display_top #(
        .SCAN_PERIOD (SCAN_PERIOD)
    ) u_dut (
        .clk         (clk),
        .arst_n      (arst_n),
        .mode        (mode),
        .number      (number),
        .tube_char   (tube_char),
        .tube_switch (tube_switch)
    );

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // amount layout worked out by repeated division by ten
    function automatic frame_t amount_frame(input logic [NUMBER_WIDTH-1:0] value);
        frame_t f;
        int     rest;
        f    = {DIGIT_COUNT{GLYPH_BLANK}};
        rest = int'(value);
        for (int i = 0; i < 4; i++) begin
            f[i] = DIGIT_GLYPHS[rest % 10];
            rest = rest / 10;
        end
        f[1][7] = 1'b0;
        return f;
    endfunction

    // position of the enabled digit
    function automatic int low_index(input logic [DIGIT_COUNT-1:0] sw);
        int idx;
        idx = 0;
        for (int i = DIGIT_COUNT - 1; i >= 0; i--) begin
            if (!sw[i]) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    task automatic check_glyph(input string name, input glyph_t expected, input glyph_t actual);
        if (actual !== expected) begin
            $display("Error: time %0t, %s expected %h, got %h", $time, name, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "glyph mismatch");
        end
    endtask

    task automatic check_switch(input string name, input logic [DIGIT_COUNT-1:0] expected,
                                input logic [DIGIT_COUNT-1:0] actual);
        if (actual !== expected) begin
            $display("Error: time %0t, %s expected %b, got %b", $time, name, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "enable mismatch");
        end
    endtask

    // apply one input pair, let it settle, then watch a full scan round
    task automatic run_vector(input mode_t m, input logic [NUMBER_WIDTH-1:0] n,
                              input frame_t expected);
        int idx;
        @(posedge clk);
        mode   <= m;
        number <= n;
        repeat (SETTLE_CYCLES) @(posedge clk);
        repeat (ROUND_CYCLES) begin
            @(negedge clk);
            idx = low_index(tube_switch);
            check_glyph($sformatf("tube_char digit %0d", idx), expected[idx], tube_char);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        arst_n        = 1'b0;
        mode          = MODE_BLANK;
        number        = '0;
        vector_count  = 0;
        total_vectors = 0;
        lcg_state     = LCG_SEED;
        rand_number   = '0;

        // unused entries keep the fill, top bit set
        for (int i = 0; i < MAX_VECTORS; i++) begin
            stim_mem[i] = '1;
        end
        $readmemh(STIM_FILE, stim_mem);
        while (vector_count < MAX_VECTORS && !stim_mem[vector_count][VEC_WIDTH-1]) begin
            vector_count++;
        end
        if (vector_count == 0) begin
            $display("no vectors could be read from %s", STIM_FILE);
            $display("*** TEST FAILED ***");
            $fatal(1, "empty stimulus");
        end
        total_vectors = vector_count + RANDOM_VECTORS;

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_switch("tube_switch", '1, tube_switch);
            check_glyph("tube_char", GLYPH_BLANK, tube_char);
        end
        @(posedge clk);
        arst_n <= 1'b1;

        for (int v = 0; v < vector_count; v++) begin
            run_vector(mode_t'(stim_mem[v][MODE_LSB +: 3]),
                       stim_mem[v][NUMBER_LSB +: NUMBER_WIDTH],
                       stim_mem[v][FRAME_LSB +: $bits(frame_t)]);
        end

        // extra amounts from the generator
        for (int r = 0; r < RANDOM_VECTORS; r++) begin
            lcg_state   = lcg_next(lcg_state);
            rand_number = lcg_state[31:16];
            run_vector(MODE_AMOUNT, rand_number, amount_frame(rand_number));
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

    // enable order and hold time, from the first edge after reset release
    initial begin : scan_monitor
        int exp_idx;
        int hold;
        exp_idx = 0;
        hold    = 0;
        wait (arst_n === 1'b1);
        @(negedge clk);
        check_switch("tube_switch", '1, tube_switch);
        forever begin
            @(negedge clk);
            check_switch("tube_switch", ~(DIGIT_COUNT'(1) << exp_idx), tube_switch);
            hold++;
            if (hold == SCAN_PERIOD) begin
                hold    = 0;
                exp_idx = (exp_idx + 1) % DIGIT_COUNT;
            end
        end
    end

    initial begin : watchdog
        int limit;
        wait (total_vectors > 0);
        limit = total_vectors * (ROUND_CYCLES + 10) * 2;
        repeat (limit) @(posedge clk);
        $display("watchdog expired after %0d cycles, the test did not finish", limit);
        $display("*** TEST FAILED ***");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

//--- bench/tube_display_stim.txt
// mode _ number _ glyphs of digits 7..4 _ glyphs of digits 3..0, all hex
// glyphs are active low, bit 7 is the decimal point
0_04D2_FFFFFFFF_FFFFFFFF
6_04D2_FFFFFFFF_F9A43099
6_0000_FFFFFFFF_C0C040C0
6_3039_FFFFFFFF_A4B01992
6_0007_FFFFFFFF_C0C040F8
6_2710_FFFFFFFF_C0C040C0
7_0000_92C1FFC0_C0C040C0
7_0009_92C1FFC0_C0C04090
7_000A_92C1FFC0_C0C079C0
7_270F_92C1FFC0_90901090
7_2710_92C1FFF9_C0C040C0
7_FFFF_92C1FF82_92923092
3_04D2_86AFFFC0_F9A43099
3_01F4_86AFFFC0_C09240C0
1_1111_FFFFFFFF_FFFFFFFF
5_FFFF_FFFFFFFF_FFFFFFFF

//--- src/bin_to_bcd.sv
`timescale 1ns/1ps
`default_nettype none

module bin_to_bcd
    import vend_pkg::*;
(
    input  wire logic [NUMBER_WIDTH-1:0] number,
    output bcd_number_t                  bcd
);

    localparam int DIGIT_WIDTH = $bits(bcd_digit_t);
    localparam int BCD_WIDTH   = $bits(bcd_number_t);
    localparam int BCD_DIGITS  = BCD_WIDTH / DIGIT_WIDTH;

    // bcd field sits above the binary field while shifting
    logic [BCD_WIDTH+NUMBER_WIDTH-1:0] dabble;

    // shift-and-add-three over every input bit
    always_comb begin
        dabble = '0;
        dabble[NUMBER_WIDTH-1:0] = number;
        for (int i = 0; i < NUMBER_WIDTH; i++) begin
            // correct any digit that would pass 9 after doubling
            for (int j = 0; j < BCD_DIGITS; j++) begin
                if (dabble[NUMBER_WIDTH + DIGIT_WIDTH*j +: DIGIT_WIDTH] > 4'd4) begin
                    dabble[NUMBER_WIDTH + DIGIT_WIDTH*j +: DIGIT_WIDTH] =
                        dabble[NUMBER_WIDTH + DIGIT_WIDTH*j +: DIGIT_WIDTH] + 4'd3;
                end
            end
            dabble = dabble << 1;
        end
    end

    assign bcd = dabble[NUMBER_WIDTH +: BCD_WIDTH];

endmodule

`default_nettype wire

//--- src/frame_composer.sv
`timescale 1ns/1ps
`default_nettype none

module frame_composer
    import tube_pkg::*;
    import vend_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        arst_n,
    input  wire mode_t       mode,
    input  wire bcd_number_t bcd,
    output frame_t           frame
);

    localparam int AMOUNT_DIGITS = 4;
    localparam int NUMBER_DIGITS = $bits(bcd_number_t) / $bits(bcd_digit_t);
    localparam int MSG_GLYPHS    = $bits(MSG_SUCCESS) / $bits(glyph_t);
    localparam int DP_DIGIT      = 1;

    frame_t next_frame;
    logic   shows_digits;

    ////////////////////////////////////////////////////////////
    // layout by mode
    ////////////////////////////////////////////////////////////

    always_comb begin
        next_frame   = {DIGIT_COUNT{GLYPH_BLANK}};
        shows_digits = 1'b0;

        case (mode)
            MODE_AMOUNT: begin
                // upper digits stay blank
                for (int i = 0; i < AMOUNT_DIGITS; i++) begin
                    next_frame[i] = seg_of_digit(bcd[i]);
                end
                shows_digits = 1'b1;
            end
            MODE_SUCCESS, MODE_FAILURE: begin
                for (int i = 0; i < NUMBER_DIGITS; i++) begin
                    next_frame[i] = seg_of_digit(bcd[i]);
                end
                // message on the leftmost digits
                if (mode == MODE_SUCCESS) begin
                    next_frame[DIGIT_COUNT-1 -: MSG_GLYPHS] = MSG_SUCCESS;
                end else begin
                    next_frame[DIGIT_COUNT-1 -: MSG_GLYPHS] = MSG_FAILURE;
                end
                shows_digits = 1'b1;
            end
            default: begin
                // blank mode and unused codes
                next_frame = {DIGIT_COUNT{GLYPH_BLANK}};
            end
        endcase

        // decimal point lit by a low bit 7
        if (shows_digits) begin
            next_frame[DP_DIGIT][7] = 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // frame register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            frame <= {DIGIT_COUNT{GLYPH_BLANK}};
        end else begin
            frame <= next_frame;
        end
    end

endmodule

`default_nettype wire

//--- src/scan_driver.sv
`timescale 1ns/1ps
`default_nettype none

module scan_driver
    import tube_pkg::*;
#(
    parameter int SCAN_PERIOD = 150000
) (
    input  wire logic                   clk,
    input  wire logic                   arst_n,
    input  wire frame_t                 frame,
    output glyph_t                      tube_char,
    output logic      [DIGIT_COUNT-1:0] tube_switch
);

    localparam int CNT_WIDTH = (SCAN_PERIOD > 1) ? $clog2(SCAN_PERIOD) : 1;

    logic [CNT_WIDTH-1:0] scan_cnt;
    digit_index_t         digit_idx;

    ////////////////////////////////////////////////////////////
    // scan timer and digit index
    ////////////////////////////////////////////////////////////

    // index moves on the last count of each period and wraps from 7 to 0
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            scan_cnt  <= '0;
            digit_idx <= '0;
        end else if (scan_cnt == CNT_WIDTH'(SCAN_PERIOD - 1)) begin
            scan_cnt  <= '0;
            digit_idx <= digit_idx + 3'd1;
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // tube outputs
    ////////////////////////////////////////////////////////////

    // one enable low at a time with the glyph of the same index
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tube_switch <= '1;
            tube_char   <= GLYPH_BLANK;
        end else begin
            tube_switch <= ~(DIGIT_COUNT'(1) << digit_idx);
            tube_char   <= frame[digit_idx];
        end
    end

endmodule

`default_nettype wire

//--- src/tube_display_top.sv
`timescale 1ns/1ps
`default_nettype none

module tube_display_top
    import tube_pkg::*;
    import vend_pkg::*;
#(
    parameter int SCAN_PERIOD = 150000
) (
    input  wire logic                    clk,
    input  wire logic                    arst_n,
    input  wire mode_t                   mode,
    input  wire logic [NUMBER_WIDTH-1:0] number,
    output glyph_t                       tube_char,
    output logic      [DIGIT_COUNT-1:0]  tube_switch
);

    bcd_number_t bcd;
    frame_t      frame;

    // number to decimal digits
    bin_to_bcd u_bcd (
        .number (number),
        .bcd    (bcd)
    );

    // frame built and held one clock
    frame_composer u_composer (
        .clk    (clk),
        .arst_n (arst_n),
        .mode   (mode),
        .bcd    (bcd),
        .frame  (frame)
    );

    // digit multiplexing
    scan_driver #(
        .SCAN_PERIOD (SCAN_PERIOD)
    ) u_scan (
        .clk         (clk),
        .arst_n      (arst_n),
        .frame       (frame),
        .tube_char   (tube_char),
        .tube_switch (tube_switch)
    );

endmodule

`default_nettype wire

//--- src/tube_pkg.sv
`default_nettype none

package tube_pkg;

    ////////////////////////////////////////////////////////////
    // display geometry
    ////////////////////////////////////////////////////////////

    localparam int DIGIT_COUNT = 8;

    // active low segments, bit 7 is the decimal point, bits 6..0 are g..a
    typedef logic [7:0] glyph_t;

    // index 0 is the rightmost digit
    typedef glyph_t [DIGIT_COUNT-1:0] frame_t;

    typedef logic [2:0] digit_index_t;

    localparam glyph_t GLYPH_BLANK = 8'hFF;

    ////////////////////////////////////////////////////////////
    // digit encoding
    ////////////////////////////////////////////////////////////

    // common anode patterns, decimal point off
    function automatic glyph_t seg_of_digit(input logic [3:0] digit);
        case (digit)
            4'd0:    return 8'hC0;
            4'd1:    return 8'hF9;
            4'd2:    return 8'hA4;
            4'd3:    return 8'hB0;
            4'd4:    return 8'h99;
            4'd5:    return 8'h92;
            4'd6:    return 8'h82;
            4'd7:    return 8'hF8;
            4'd8:    return 8'h80;
            4'd9:    return 8'h90;
            default: return GLYPH_BLANK;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- src/vend_pkg.sv
`default_nettype none

package vend_pkg;

    localparam int NUMBER_WIDTH = 16;

    typedef logic [3:0] bcd_digit_t;

    // index 0 holds the units digit
    typedef bcd_digit_t [4:0] bcd_number_t;

    // codes follow the vending controller's mode bus
    typedef enum logic [2:0] {
        MODE_BLANK   = 3'd0,
        MODE_FAILURE = 3'd3,
        MODE_AMOUNT  = 3'd6,
        MODE_SUCCESS = 3'd7
    } mode_t;

    ////////////////////////////////////////////////////////////
    // message glyphs, leftmost glyph at index 2
    ////////////////////////////////////////////////////////////

    // "S", "U", blank
    localparam tube_pkg::glyph_t [2:0] MSG_SUCCESS = {8'h92, 8'hC1, 8'hFF};

    // "E", "r", blank
    localparam tube_pkg::glyph_t [2:0] MSG_FAILURE = {8'h86, 8'hAF, 8'hFF};

endpackage

`default_nettype wire

//--- tube_display_top.f
src/tube_pkg.sv
src/vend_pkg.sv
src/bin_to_bcd.sv
src/frame_composer.sv
src/scan_driver.sv
src/tube_display_top.sv
bench/tb_tube_display.sv
